// ==== udp_reg_panel.f ====
hw/udp_reg_panel_pkg.sv
hw/udp_cmd_parser.sv
hw/reg_bank.sv
hw/udp_reply_gen.sv
hw/panel_display.sv
hw/udp_reg_panel.sv
sim/udp_reg_panel_asserts.sv
sim/tb_udp_reg_panel.sv

// ==== Bender.yml ====
package:
  name: udp_reg_panel

sources:
  - files:
      - hw/udp_reg_panel_pkg.sv
      - hw/udp_cmd_parser.sv
      - hw/reg_bank.sv
      - hw/udp_reply_gen.sv
      - hw/panel_display.sv
      - hw/udp_reg_panel.sv
  - target: simulation
    files:
      - sim/udp_reg_panel_asserts.sv
      - sim/tb_udp_reg_panel.sv

// ==== sim/tb_udp_reg_panel.sv ====
// testbench for the udp register panel
// drives command frames, models the register bank and checks
// every reply byte, the led byte and the seven-segment digits

`timescale 1ns/100ps

module tb_udp_reg_panel;

  localparam int TIMEOUT = 200;
  // active-high hex font, bit 0 is segment a
  localparam logic [6:0] FONT [16] = '{
    7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
    7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
  };

  logic            clk;
  logic            rst;
  logic [7:0]      rx_tdata;
  logic            rx_tvalid;
  logic            rx_tlast;
  logic            rx_tready;
  logic [31:0]     src_ip;
  logic [7:0]      tx_tdata;
  logic            tx_tvalid;
  logic            tx_tlast;
  logic            tx_tready;
  logic [2:0]      sel;
  logic [7:0][6:0] hex;
  logic [7:0]      led;
  // reference model state
  logic [31:0]     ref_regs [4];
  logic [31:0]     ref_ip;
  integer          seed;
  bit              stall_en;

  udp_reg_panel DUT (
    .clk         (clk),
    .rst         (rst),
    .i_rx_tdata  (rx_tdata),
    .i_rx_tvalid (rx_tvalid),
    .i_rx_tlast  (rx_tlast),
    .o_rx_tready (rx_tready),
    .i_src_ip    (src_ip),
    .o_tx_tdata  (tx_tdata),
    .o_tx_tvalid (tx_tvalid),
    .o_tx_tlast  (tx_tlast),
    .i_tx_tready (tx_tready),
    .i_sel       (sel),
    .o_hex       (hex),
    .o_led       (led)
  );

  bind udp_reg_panel udp_reg_panel_asserts u_asserts (
    .clk (clk), .rst (rst),
    .i_rx_tdata (i_rx_tdata), .i_rx_tvalid (i_rx_tvalid), .i_rx_tlast (i_rx_tlast),
    .o_rx_tready (o_rx_tready),
    .o_tx_tdata (o_tx_tdata), .o_tx_tvalid (o_tx_tvalid), .o_tx_tlast (o_tx_tlast),
    .i_tx_tready (i_tx_tready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // a protocol assertion ends the run at once
  always @(posedge clk) begin
    if (DUT.u_asserts.err_cnt != 0) begin
      $display("ERROR: a protocol assertion failed");
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("FAILED %s expected %0h actual %0h", name, exp, act);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic fail_text(input string msg);
    $display("ERROR: %s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // one receive beat, held until taken
  // ready is registered, so the negedge value holds at the edge
  task automatic send_byte(input logic [7:0] data, input logic last);
    bit taken;
    int waited;
    rx_tdata  = data;
    rx_tvalid = 1'b1;
    rx_tlast  = last;
    taken     = 1'b0;
    waited    = 0;
    while (!taken) begin
      @(negedge clk);
      taken = rx_tready;
      @(posedge clk);
      #1;
      waited++;
      if (!taken && waited > TIMEOUT) fail_text("receive side never became ready");
    end
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
  endtask

  // five reply beats, random stalls when enabled
  task automatic take_reply(input logic [7:0] cmd, input logic [31:0] data);
    logic [39:0] exp_word;
    logic [7:0]  exp_byte;
    int          beat;
    int          waited;
    exp_word = {cmd, data};
    beat     = 0;
    waited   = 0;
    while (beat < 5) begin
      tx_tready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
      @(negedge clk);
      if (tx_tvalid && tx_tready) begin
        exp_byte = exp_word[(4 - beat) * 8 +: 8];
        assert (tx_tdata == exp_byte) else fail_value("o_tx_tdata", exp_byte, tx_tdata);
        assert (tx_tlast == (beat == 4)) else fail_value("o_tx_tlast", beat == 4, tx_tlast);
        beat++;
        waited = 0;
      end
      @(posedge clk);
      #1;
      waited++;
      if (waited > TIMEOUT) fail_text("reply stalled or never started");
    end
    tx_tready = 1'b1;
    // leds keep the first byte of the finished reply
    @(negedge clk);
    assert (led == cmd) else fail_value("o_led", cmd, led);
    @(posedge clk);
    #1;
  endtask

  // good read or write, model updated before the reply
  task automatic run_cmd(input logic write, input logic [1:0] idx, input logic [31:0] data);
    logic [7:0] cmd;
    cmd    = {write, 5'($random(seed)), idx};
    src_ip = $random(seed);
    send_byte(cmd, !write);
    if (write) begin
      for (int i = 3; i >= 0; i--) begin
        send_byte(data[i*8 +: 8], i == 0);
      end
      ref_regs[idx] = data;
    end
    ref_ip = src_ip;
    take_reply(cmd, ref_regs[idx]);
  endtask

  // wrong-length frame, must be dropped without reply
  task automatic send_bad(input logic write, input int len);
    logic [7:0] cmd;
    int         quiet;
    cmd    = {write, 5'($random(seed)), 2'($random(seed))};
    src_ip = $random(seed);
    for (int i = 0; i < len; i++) begin
      send_byte((i == 0) ? cmd : 8'($random(seed)), i == len - 1);
    end
    for (quiet = 0; quiet < 20; quiet++) begin
      @(negedge clk);
      assert (!tx_tvalid) else fail_text("reply sent for a malformed frame");
      @(posedge clk);
      #1;
    end
  endtask

  // every switch setting, unused codes show zero
  task automatic check_display();
    logic [31:0]     word;
    logic [7:0][6:0] exp_hex;
    for (int s = 0; s < 8; s++) begin
      sel = 3'(s);
      if (s < 4) word = ref_regs[s];
      else if (s == 4) word = ref_ip;
      else word = '0;
      for (int d = 0; d < 8; d++) begin
        exp_hex[d] = ~FONT[word[d*4 +: 4]];
      end
      @(negedge clk);
      assert (hex == exp_hex) else fail_value("o_hex", exp_hex, hex);
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    seed      = 32'hcf42_ff09;
    stall_en  = 1'b0;
    rst       = 1'b1;
    rx_tdata  = '0;
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
    src_ip    = '0;
    tx_tready = 1'b1;
    sel       = '0;
    ref_ip    = '0;
    for (int i = 0; i < 4; i++) begin
      ref_regs[i] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    assert (led == 8'h00) else fail_value("o_led", 0, led);
    @(posedge clk);
    #1;
    check_display();
    // reads straight after reset
    for (int i = 0; i < 4; i++) begin
      run_cmd(1'b0, 2'(i), '0);
    end
    // writes and reads with transmit stalls
    stall_en = 1'b1;
    repeat (12) begin
      run_cmd(1'b1, 2'($random(seed)), $random(seed));
      run_cmd(1'b0, 2'($random(seed)), '0);
    end
    check_display();
    // short write, long write, padded read
    send_bad(1'b1, 2);
    send_bad(1'b1, 6);
    send_bad(1'b0, 3);
    check_display();
    for (int i = 0; i < 4; i++) begin
      run_cmd(1'b0, 2'(i), '0);
    end
    check_display();
    if (DUT.u_asserts.err_cnt == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== sim/udp_reg_panel_asserts.sv ====
// protocol checks for the udp register panel
// transmit hold under stall, reset state, receive ready while a
// command is outstanding and the fixed latency from a good last
// byte to the reply

`timescale 1ns/100ps

module udp_reg_panel_asserts (
  input logic                                 clk,
  input logic                                 rst,
  input logic [udp_reg_panel_pkg::BYTE_W-1:0] i_rx_tdata,
  input logic                                 i_rx_tvalid,
  input logic                                 i_rx_tlast,
  input logic                                 o_rx_tready,
  input logic [udp_reg_panel_pkg::BYTE_W-1:0] o_tx_tdata,
  input logic                                 o_tx_tvalid,
  input logic                                 o_tx_tlast,
  input logic                                 i_tx_tready
);

  int         err_cnt = 0;
  // own byte count, saturating past a write frame
  logic [2:0] seen;
  logic       wr_flag;
  logic       rx_fire;
  logic       cur_write;
  logic       good_last;
  // set by a good frame, cleared by the last reply beat
  logic       pending;

  assign rx_fire   = i_rx_tvalid & o_rx_tready;
  assign cur_write = (seen == 0) ? i_rx_tdata[udp_reg_panel_pkg::CMD_WRITE_BIT] : wr_flag;
  assign good_last = rx_fire & i_rx_tlast &
                     (cur_write ? (seen == udp_reg_panel_pkg::WRITE_LEN - 1) :
                                  (seen == udp_reg_panel_pkg::READ_LEN - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      seen    <= '0;
      wr_flag <= 1'b0;
    end else if (rx_fire) begin
      if (seen == 0) begin
        wr_flag <= i_rx_tdata[udp_reg_panel_pkg::CMD_WRITE_BIT];
      end
      if (i_rx_tlast) begin
        seen <= '0;
      end else if (seen != udp_reg_panel_pkg::WRITE_LEN) begin
        seen <= seen + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (good_last) begin
      pending <= 1'b1;
    end else if (o_tx_tvalid && i_tx_tready && o_tx_tlast) begin
      pending <= 1'b0;
    end
  end

  // stalled beat keeps its data and last flag
  tx_hold: assert property (@(posedge clk) disable iff (rst)
    o_tx_tvalid && !i_tx_tready |=> o_tx_tvalid && $stable(o_tx_tdata) && $stable(o_tx_tlast))
    else begin
      err_cnt++;
      $error("transmit beat changed while stalled");
    end

  reset_quiet: assert property (@(posedge clk) rst |=> !o_tx_tvalid)
    else begin
      err_cnt++;
      $error("transmit valid high during reset");
    end

  // only one command in flight
  // low from the command pulse to the last accepted beat
  rx_stall: assert property (@(posedge clk) disable iff (rst) o_rx_tready == !pending)
    else begin
      err_cnt++;
      $error("receive ready wrong for the outstanding command state");
    end

  reply_latency: assert property (@(posedge clk) disable iff (rst)
    good_last |-> ##2 $rose(o_tx_tvalid))
    else begin
      err_cnt++;
      $error("reply did not start two cycles after a good frame");
    end

endmodule

// ==== hw/udp_reg_panel.sv ====
// udp register panel top level
// payload command parser, four-register bank, reply generator
// and seven-segment display on one clock

`timescale 1ns/100ps

module udp_reg_panel (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [udp_reg_panel_pkg::BYTE_W-1:0]     i_rx_tdata,
  input  logic                                    i_rx_tvalid,
  input  logic                                    i_rx_tlast,
  output logic                                    o_rx_tready,
  input  logic [udp_reg_panel_pkg::IP_W-1:0]       i_src_ip,
  output logic [udp_reg_panel_pkg::BYTE_W-1:0]     o_tx_tdata,
  output logic                                    o_tx_tvalid,
  output logic                                    o_tx_tlast,
  input  logic                                    i_tx_tready,
  input  logic [udp_reg_panel_pkg::DISP_SEL_W-1:0] i_sel,
  output logic [udp_reg_panel_pkg::HEX_DIGITS-1:0][udp_reg_panel_pkg::SEG_W-1:0] o_hex,
  output logic [udp_reg_panel_pkg::BYTE_W-1:0]     o_led
);

  // command from parser
  logic                                   cmd_valid;
  logic [udp_reg_panel_pkg::BYTE_W-1:0]    cmd_byte;
  logic [udp_reg_panel_pkg::REG_IDX_W-1:0] cmd_idx;
  logic [udp_reg_panel_pkg::REG_W-1:0]     cmd_wdata;
  logic [udp_reg_panel_pkg::IP_W-1:0]      cmd_src_ip;
  // bank results and reply status
  logic [udp_reg_panel_pkg::REG_W-1:0]     rd_data;
  udp_reg_panel_pkg::disp_word_u           regs [udp_reg_panel_pkg::REGS_NUM];
  logic                                   reply_busy;

  udp_cmd_parser u_parser (
    .clk          (clk),
    .rst          (rst),
    .i_rx_tdata   (i_rx_tdata),
    .i_rx_tvalid  (i_rx_tvalid),
    .i_rx_tlast   (i_rx_tlast),
    .o_rx_tready  (o_rx_tready),
    .i_src_ip     (i_src_ip),
    .i_reply_busy (reply_busy),
    .o_cmd_valid  (cmd_valid),
    .o_cmd_byte   (cmd_byte),
    .o_cmd_idx    (cmd_idx),
    .o_cmd_wdata  (cmd_wdata),
    .o_cmd_src_ip (cmd_src_ip)
  );

  // write flag comes straight from the command byte
  reg_bank u_bank (
    .clk         (clk),
    .rst         (rst),
    .i_cmd_valid (cmd_valid),
    .i_cmd_write (cmd_byte[udp_reg_panel_pkg::CMD_WRITE_BIT]),
    .i_cmd_idx   (cmd_idx),
    .i_cmd_wdata (cmd_wdata),
    .o_rd_data   (rd_data),
    .o_regs      (regs)
  );

  udp_reply_gen u_reply (
    .clk         (clk),
    .rst         (rst),
    .i_cmd_valid (cmd_valid),
    .i_cmd_byte  (cmd_byte),
    .i_rd_data   (rd_data),
    .o_tx_tdata  (o_tx_tdata),
    .o_tx_tvalid (o_tx_tvalid),
    .o_tx_tlast  (o_tx_tlast),
    .i_tx_tready (i_tx_tready),
    .o_busy      (reply_busy),
    .o_led       (o_led)
  );

  panel_display u_display (
    .clk          (clk),
    .rst          (rst),
    .i_sel        (i_sel),
    .i_regs       (regs),
    .i_cmd_valid  (cmd_valid),
    .i_cmd_src_ip (cmd_src_ip),
    .o_hex        (o_hex)
  );

endmodule

// ==== hw/panel_display.sv ====
// seven-segment panel
// shows a switch-selected register or the sender address of the
// last good command on eight active-low hex digits

`timescale 1ns/100ps

module panel_display (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [udp_reg_panel_pkg::DISP_SEL_W-1:0] i_sel,
  input  udp_reg_panel_pkg::disp_word_u            i_regs [udp_reg_panel_pkg::REGS_NUM],
  input  logic                                    i_cmd_valid,
  input  logic [udp_reg_panel_pkg::IP_W-1:0]       i_cmd_src_ip,
  output logic [udp_reg_panel_pkg::HEX_DIGITS-1:0][udp_reg_panel_pkg::SEG_W-1:0] o_hex
);

  udp_reg_panel_pkg::disp_word_u ip_r;
  udp_reg_panel_pkg::disp_word_u shown;

  // sender of the last good command
  always_ff @(posedge clk) begin
    if (rst) begin
      ip_r.word <= '0;
    end else if (i_cmd_valid) begin
      ip_r.word <= i_cmd_src_ip;
    end
  end

  // source select, unused codes blank to zero
  always_comb begin
    shown.word = '0;
    if (i_sel < udp_reg_panel_pkg::REGS_NUM) begin
      shown = i_regs[i_sel[udp_reg_panel_pkg::REG_IDX_W-1:0]];
    end else if (i_sel == udp_reg_panel_pkg::SEL_SRC_IP) begin
      shown = ip_r;
    end
  end

  // font lookup per nibble
  // segments are driven low to light
  always_comb begin
    for (int i = 0; i < udp_reg_panel_pkg::HEX_DIGITS; i++) begin
      o_hex[i] = ~udp_reg_panel_pkg::SEG_FONT[shown.digit[i]*udp_reg_panel_pkg::SEG_W +:
                                               udp_reg_panel_pkg::SEG_W];
    end
  end

endmodule

// ==== hw/udp_reply_gen.sv ====
// reply generator
// sends the echoed command byte and the read word, msb first,
// as a five-byte payload under back-pressure, and keeps the
// first byte of each reply for the green leds

`timescale 1ns/100ps

module udp_reply_gen (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_cmd_valid,
  input  logic [udp_reg_panel_pkg::BYTE_W-1:0] i_cmd_byte,
  input  logic [udp_reg_panel_pkg::REG_W-1:0]  i_rd_data,
  output logic [udp_reg_panel_pkg::BYTE_W-1:0] o_tx_tdata,
  output logic                                o_tx_tvalid,
  output logic                                o_tx_tlast,
  input  logic                                i_tx_tready,
  output logic                                o_busy,
  output logic [udp_reg_panel_pkg::BYTE_W-1:0] o_led
);

  logic [udp_reg_panel_pkg::BYTE_W-1:0]                      cmd_r;
  logic [udp_reg_panel_pkg::REG_W-1:0]                       data_r;
  logic [udp_reg_panel_pkg::REPLY_LEN*udp_reg_panel_pkg::BYTE_W-1:0] reply_word;
  logic [$clog2(udp_reg_panel_pkg::REPLY_LEN)-1:0]           beat_cnt;
  logic                                                      load_rd;
  logic                                                      tx_fire;

  assign tx_fire = o_tx_tvalid & i_tx_tready;

  // busy covers the command pulse and the whole reply
  assign o_busy = i_cmd_valid | o_tx_tvalid;

  // command byte leads, then data msb first
  assign reply_word = {cmd_r, data_r};
  assign o_tx_tdata =
    reply_word[(udp_reg_panel_pkg::REPLY_LEN-1-beat_cnt)*udp_reg_panel_pkg::BYTE_W +:
               udp_reg_panel_pkg::BYTE_W];
  assign o_tx_tlast = o_tx_tvalid & (beat_cnt == udp_reg_panel_pkg::REPLY_LEN - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_tx_tvalid <= 1'b0;
      beat_cnt    <= '0;
      load_rd     <= 1'b0;
      o_led       <= '0;
    end else begin
      // bank output settles one cycle after the pulse
      load_rd <= i_cmd_valid;
      if (i_cmd_valid) begin
        o_tx_tvalid <= 1'b1;
        beat_cnt    <= '0;
      end else if (tx_fire) begin
        if (o_tx_tlast) begin
          o_tx_tvalid <= 1'b0;
          beat_cnt    <= '0;
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
      // first accepted byte goes to the leds
      if (tx_fire && beat_cnt == '0) begin
        o_led <= o_tx_tdata;
      end
    end
  end

  // payload holding registers
  // data_r lands before beat 1 can be shown
  always_ff @(posedge clk) begin
    if (i_cmd_valid) begin
      cmd_r <= i_cmd_byte;
    end
    if (load_rd) begin
      data_r <= i_rd_data;
    end
  end

endmodule

// ==== hw/reg_bank.sv ====
// four-word register bank
// applies write commands and returns the addressed word,
// after any write, for the reply of each command

`timescale 1ns/100ps

module reg_bank (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   i_cmd_valid,
  input  logic                                   i_cmd_write,
  input  logic [udp_reg_panel_pkg::REG_IDX_W-1:0] i_cmd_idx,
  input  logic [udp_reg_panel_pkg::REG_W-1:0]     i_cmd_wdata,
  output logic [udp_reg_panel_pkg::REG_W-1:0]     o_rd_data,
  output udp_reg_panel_pkg::disp_word_u           o_regs [udp_reg_panel_pkg::REGS_NUM]
);

  // register store, cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < udp_reg_panel_pkg::REGS_NUM; i++) begin
        o_regs[i].word <= '0;
      end
    end else if (i_cmd_valid && i_cmd_write) begin
      o_regs[i_cmd_idx].word <= i_cmd_wdata;
    end
  end

  // read back for the reply
  // a write returns the value it stores
  always_ff @(posedge clk) begin
    if (i_cmd_valid) begin
      if (i_cmd_write) begin
        o_rd_data <= i_cmd_wdata;
      end else begin
        o_rd_data <= o_regs[i_cmd_idx].word;
      end
    end
  end

endmodule

// ==== hw/udp_cmd_parser.sv ====
// udp payload command parser
// counts bytes of each receive frame, keeps the command byte,
// sender address and write word, and pulses one command for
// every well-formed frame; other frames are drained and dropped

`timescale 1ns/100ps

module udp_cmd_parser (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [udp_reg_panel_pkg::BYTE_W-1:0]    i_rx_tdata,
  input  logic                                   i_rx_tvalid,
  input  logic                                   i_rx_tlast,
  output logic                                   o_rx_tready,
  input  logic [udp_reg_panel_pkg::IP_W-1:0]      i_src_ip,
  input  logic                                   i_reply_busy,
  output logic                                   o_cmd_valid,
  output logic [udp_reg_panel_pkg::BYTE_W-1:0]    o_cmd_byte,
  output logic [udp_reg_panel_pkg::REG_IDX_W-1:0] o_cmd_idx,
  output logic [udp_reg_panel_pkg::REG_W-1:0]     o_cmd_wdata,
  output logic [udp_reg_panel_pkg::IP_W-1:0]      o_cmd_src_ip
);

  // bytes already taken in this frame, sticks at WRITE_LEN
  logic [$clog2(udp_reg_panel_pkg::WRITE_LEN+1)-1:0] byte_cnt;
  logic [udp_reg_panel_pkg::BYTE_W-1:0]              cmd_r;
  logic [udp_reg_panel_pkg::REG_W-1:0]               wdata_r;
  logic [udp_reg_panel_pkg::IP_W-1:0]                src_ip_r;
  logic [udp_reg_panel_pkg::BYTE_W-1:0]              cur_cmd;
  logic                                              rx_fire;
  logic                                              good_frame;

  // stall input while a command is in flight
  assign o_rx_tready = ~(o_cmd_valid | i_reply_busy);
  assign rx_fire     = i_rx_tvalid & o_rx_tready;

  // a one byte frame ends on its own command byte
  assign cur_cmd = (byte_cnt == '0) ? i_rx_tdata : cmd_r;

  // length check against the write flag, valid on the last beat
  always_comb begin
    if (cur_cmd[udp_reg_panel_pkg::CMD_WRITE_BIT]) begin
      good_frame = (byte_cnt == udp_reg_panel_pkg::WRITE_LEN - 1);
    end else begin
      good_frame = (byte_cnt == udp_reg_panel_pkg::READ_LEN - 1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      byte_cnt    <= '0;
      o_cmd_valid <= 1'b0;
    end else begin
      // one cycle after the final byte
      o_cmd_valid <= rx_fire & i_rx_tlast & good_frame;
      if (rx_fire) begin
        if (i_rx_tlast) begin
          byte_cnt <= '0;
        end else if (byte_cnt != udp_reg_panel_pkg::WRITE_LEN) begin
          byte_cnt <= byte_cnt + 1'b1;
        end
      end
    end
  end

  // command and sender taken with byte 0
  // data bytes shift in msb first
  always_ff @(posedge clk) begin
    if (rx_fire && byte_cnt == '0) begin
      cmd_r    <= i_rx_tdata;
      src_ip_r <= i_src_ip;
    end
    if (rx_fire && byte_cnt != '0) begin
      wdata_r <= {wdata_r[udp_reg_panel_pkg::REG_W-udp_reg_panel_pkg::BYTE_W-1:0], i_rx_tdata};
    end
  end

  assign o_cmd_byte   = cmd_r;
  assign o_cmd_idx    = cmd_r[udp_reg_panel_pkg::REG_IDX_W-1:0];
  assign o_cmd_wdata  = wdata_r;
  assign o_cmd_src_ip = src_ip_r;

endmodule

// ==== hw/udp_reg_panel_pkg.sv ====
// udp register panel shared definitions
// widths, command protocol constants, seven-segment font
// and the display word that is read both as a word and as digits

package udp_reg_panel_pkg;

  // datapath widths
  localparam int BYTE_W     = 8;
  localparam int REG_W      = 32;
  localparam int REGS_NUM   = 4;
  localparam int REG_IDX_W  = 2;
  localparam int IP_W       = 32;

  // display geometry
  localparam int HEX_DIGITS = 8;
  localparam int SEG_W      = 7;
  localparam int DISP_SEL_W = 3;
  // switch value that shows the sender address
  localparam int SEL_SRC_IP = 4;

  // command byte layout, index sits in the low bits
  localparam int CMD_WRITE_BIT = 7;

  // frame lengths in payload bytes
  localparam int WRITE_LEN = 5;
  localparam int READ_LEN  = 1;
  // echoed command plus four data bytes
  localparam int REPLY_LEN = 5;

  // active-high segments, bit 0 is segment a
  // entry n sits at [n*SEG_W +: SEG_W]
  localparam logic [16*SEG_W-1:0] SEG_FONT = {
    7'h71, 7'h79, 7'h5E, 7'h39,   // F E d C
    7'h7C, 7'h77, 7'h6F, 7'h7F,   // b A 9 8
    7'h07, 7'h7D, 7'h6D, 7'h66,   // 7 6 5 4
    7'h4F, 7'h5B, 7'h06, 7'h3F    // 3 2 1 0
  };

  // register word, also seen as hex nibbles
  // digit[0] is the least significant nibble
  typedef union packed {
    logic [REG_W-1:0]        word;
    logic [HEX_DIGITS-1:0][3:0] digit;
  } disp_word_u;

endpackage
